/* Makefile */
VERILATOR ?= verilator
TOP       ?= ooo_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "tests failed" $(LOG) || [ $$status -ne 0 ]; then exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* rtl/cdb_if.sv */
`timescale 1ns/1ps

interface cdb_if;
    import ooo_pkg::*;

    // one result per cycle at most
    logic  valid;
    prn_t  prn;
    robn_t robn;
    word_t value;

    modport source (output valid, prn, robn, value);
    modport sink (input valid, prn, robn, value);

endinterface

/* rtl/dispatch_if.sv */
`timescale 1ns/1ps

interface dispatch_if;
    import ooo_pkg::*;

    logic  valid;
    op_e   op;
    word_t imm;
    arn_t  dest_arn;
    prn_t  dest_prn;
    prn_t  old_prn;
    prn_t  src1_prn;
    prn_t  src2_prn;
    robn_t robn;

    modport rename (
        output valid, op, imm, dest_arn, dest_prn, old_prn, src1_prn, src2_prn, robn
    );
    modport issue (input valid, op, imm, dest_prn, src1_prn, src2_prn, robn);
    modport rob (input valid, dest_arn, old_prn, robn);

endinterface

/* rtl/issue_exec.sv */
`timescale 1ns/1ps

module issue_exec (
    input  logic           clock,
    input  logic           rst_n,
    dispatch_if.issue      disp,
    output logic           iq_full,
    output logic           alloc_valid,
    output ooo_pkg::prn_t  alloc_prn,
    output ooo_pkg::prn_t  rd_prn [2],
    input  logic           rd_ready [2],
    output ooo_pkg::prn_t  ex_prn [2],
    input  ooo_pkg::word_t ex_value [2],
    cdb_if.source          cdb
);
    import ooo_pkg::*;

    logic [IQ_DEPTH-1:0] q_valid;
    logic [IQ_DEPTH-1:0] q_rdy1;
    logic [IQ_DEPTH-1:0] q_rdy2;
    logic [IQ_IDX_W-1:0] q_age [IQ_DEPTH];
    op_e                 q_op [IQ_DEPTH];
    word_t               q_imm [IQ_DEPTH];
    prn_t                q_dest [IQ_DEPTH];
    prn_t                q_src1 [IQ_DEPTH];
    prn_t                q_src2 [IQ_DEPTH];
    robn_t               q_robn [IQ_DEPTH];

    logic [IQ_IDX_W-1:0] sel_idx;
    logic [IQ_IDX_W-1:0] free_idx;
    logic [IQ_IDX_W-1:0] new_age;
    logic                sel_found;
    logic                wake1;
    logic                wake2;
    word_t               opnd_b;
    word_t               alu_out;

    // age counts older entries, so the oldest ready one has the lowest age
    always_comb begin
        sel_found = 1'b0;
        sel_idx   = '0;
        free_idx  = '0;
        new_age   = '0;
        for (int i = IQ_DEPTH - 1; i >= 0; i--) begin
            if (!q_valid[i]) begin
                free_idx = IQ_IDX_W'(i);
            end
        end
        for (int i = 0; i < IQ_DEPTH; i++) begin
            if (q_valid[i] && q_rdy1[i] && q_rdy2[i] &&
                (!sel_found || q_age[i] < q_age[sel_idx])) begin
                sel_found = 1'b1;
                sel_idx   = IQ_IDX_W'(i);
            end
            if (q_valid[i]) begin
                new_age = new_age + 1'b1;
            end
        end
        if (sel_found) begin
            new_age = new_age - 1'b1;
        end
    end

    assign iq_full     = &q_valid;
    assign alloc_valid = disp.valid;
    assign alloc_prn   = disp.dest_prn;
    assign rd_prn[0]   = disp.src1_prn;
    assign rd_prn[1]   = disp.src2_prn;
    assign ex_prn[0]   = q_src1[sel_idx];
    assign ex_prn[1]   = q_src2[sel_idx];

    // a result on the bus this cycle also counts at dispatch
    assign wake1 = rd_ready[0] | (cdb.valid && cdb.prn == disp.src1_prn);
    assign wake2 = (disp.op == OP_ADDI) | rd_ready[1] |
                   (cdb.valid && cdb.prn == disp.src2_prn);

    assign opnd_b = (q_op[sel_idx] == OP_ADDI) ? q_imm[sel_idx] : ex_value[1];

    always_comb begin
        case (q_op[sel_idx])
            OP_ADD, OP_ADDI: alu_out = ex_value[0] + opnd_b;
            OP_SUB:          alu_out = ex_value[0] - opnd_b;
            OP_AND:          alu_out = ex_value[0] & opnd_b;
            OP_XOR:          alu_out = ex_value[0] ^ opnd_b;
            default:         alu_out = '0;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            q_valid   <= '0;
            q_rdy1    <= '0;
            q_rdy2    <= '0;
            cdb.valid <= 1'b0;
            for (int i = 0; i < IQ_DEPTH; i++) begin
                q_age[i] <= '0;
            end
        end else begin
            for (int i = 0; i < IQ_DEPTH; i++) begin
                if (cdb.valid && cdb.prn == q_src1[i]) begin
                    q_rdy1[i] <= 1'b1;
                end
                if (cdb.valid && cdb.prn == q_src2[i]) begin
                    q_rdy2[i] <= 1'b1;
                end
                if (sel_found && q_valid[i] && q_age[i] > q_age[sel_idx]) begin
                    q_age[i] <= q_age[i] - 1'b1;
                end
            end
            if (sel_found) begin
                q_valid[sel_idx] <= 1'b0;
            end
            if (disp.valid) begin
                q_valid[free_idx] <= 1'b1;
                q_rdy1[free_idx]  <= wake1;
                q_rdy2[free_idx]  <= wake2;
                q_age[free_idx]   <= new_age;
            end
            cdb.valid <= sel_found;
        end
    end

    always_ff @(posedge clock) begin
        if (disp.valid) begin
            q_op[free_idx]   <= disp.op;
            q_imm[free_idx]  <= disp.imm;
            q_dest[free_idx] <= disp.dest_prn;
            q_src1[free_idx] <= disp.src1_prn;
            q_src2[free_idx] <= disp.src2_prn;
            q_robn[free_idx] <= disp.robn;
        end
        // ALU stage register
        if (sel_found) begin
            cdb.prn   <= q_dest[sel_idx];
            cdb.robn  <= q_robn[sel_idx];
            cdb.value <= alu_out;
        end
    end

endmodule

/* rtl/ooo_core.sv */
`timescale 1ns/1ps

module ooo_core (
    input  logic           clock,
    input  logic           rst_n,
    input  logic           in_valid,
    input  ooo_pkg::op_e   in_op,
    input  ooo_pkg::arn_t  in_dest,
    input  ooo_pkg::arn_t  in_src1,
    input  ooo_pkg::arn_t  in_src2,
    input  ooo_pkg::word_t in_imm,
    output logic           stall,
    output logic           commit_valid,
    output ooo_pkg::arn_t  commit_arn,
    output ooo_pkg::word_t commit_value
);
    import ooo_pkg::*;

    logic  rob_full;
    logic  iq_full;
    robn_t rob_tail;
    logic  free_valid;
    prn_t  free_prn;
    logic  alloc_valid;
    prn_t  alloc_prn;
    prn_t  rd_prn [2];
    logic  rd_ready [2];
    prn_t  ex_prn [2];
    word_t ex_value [2];

    dispatch_if disp ();
    cdb_if      cdb ();

    rename_stage rename_inst (
        .clock      (clock),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_op      (in_op),
        .in_dest    (in_dest),
        .in_src1    (in_src1),
        .in_src2    (in_src2),
        .in_imm     (in_imm),
        .rob_full   (rob_full),
        .iq_full    (iq_full),
        .rob_tail   (rob_tail),
        .free_valid (free_valid),
        .free_prn   (free_prn),
        .stall      (stall),
        .disp       (disp.rename)
    );

    // operand values are read at select, only ready bits at dispatch
    phys_regfile prf_inst (
        .clock       (clock),
        .rst_n       (rst_n),
        .cdb         (cdb.sink),
        .alloc_valid (alloc_valid),
        .alloc_prn   (alloc_prn),
        .rd_prn      (rd_prn),
        .rd_value    (),
        .rd_ready    (rd_ready),
        .ex_prn      (ex_prn),
        .ex_value    (ex_value)
    );

    issue_exec issue_inst (
        .clock       (clock),
        .rst_n       (rst_n),
        .disp        (disp.issue),
        .iq_full     (iq_full),
        .alloc_valid (alloc_valid),
        .alloc_prn   (alloc_prn),
        .rd_prn      (rd_prn),
        .rd_ready    (rd_ready),
        .ex_prn      (ex_prn),
        .ex_value    (ex_value),
        .cdb         (cdb.source)
    );

    reorder_buffer rob_inst (
        .clock        (clock),
        .rst_n        (rst_n),
        .disp         (disp.rob),
        .cdb          (cdb.sink),
        .rob_full     (rob_full),
        .rob_tail     (rob_tail),
        .free_valid   (free_valid),
        .free_prn     (free_prn),
        .commit_valid (commit_valid),
        .commit_arn   (commit_arn),
        .commit_value (commit_value)
    );

endmodule

/* rtl/ooo_pkg.sv */
package ooo_pkg;

    localparam int XLEN      = 16;
    localparam int ARCH_REGS = 8;
    localparam int PHYS_REGS = 16;
    localparam int ROB_DEPTH = 8;
    localparam int IQ_DEPTH  = 4;

    // derived sizes
    localparam int FREE_REGS = PHYS_REGS - ARCH_REGS;
    localparam int IQ_IDX_W  = $clog2(IQ_DEPTH);

    typedef logic [XLEN-1:0]              word_t;
    typedef logic [$clog2(ARCH_REGS)-1:0] arn_t;
    typedef logic [$clog2(PHYS_REGS)-1:0] prn_t;
    typedef logic [$clog2(ROB_DEPTH)-1:0] robn_t;

    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_AND  = 3'd2,
        OP_XOR  = 3'd3,
        OP_ADDI = 3'd4
    } op_e;

endpackage

/* rtl/phys_regfile.sv */
`timescale 1ns/1ps

module phys_regfile (
    input  logic           clock,
    input  logic           rst_n,
    cdb_if.sink            cdb,
    input  logic           alloc_valid,
    input  ooo_pkg::prn_t  alloc_prn,
    input  ooo_pkg::prn_t  rd_prn [2],
    output ooo_pkg::word_t rd_value [2],
    output logic           rd_ready [2],
    input  ooo_pkg::prn_t  ex_prn [2],
    output ooo_pkg::word_t ex_value [2]
);
    import ooo_pkg::*;

    word_t                values [PHYS_REGS];
    logic [PHYS_REGS-1:0] ready;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < PHYS_REGS; i++) begin
                values[i] <= '0;
                ready[i]  <= (i < ARCH_REGS);
            end
        end else begin
            if (alloc_valid) begin
                ready[alloc_prn] <= 1'b0;
            end
            // bus write after alloc so it wins on a clash
            if (cdb.valid) begin
                values[cdb.prn] <= cdb.value;
                ready[cdb.prn]  <= 1'b1;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            rd_value[i] = values[rd_prn[i]];
            rd_ready[i] = ready[rd_prn[i]];
            ex_value[i] = values[ex_prn[i]];
        end
    end

endmodule

/* rtl/rename_stage.sv */
`timescale 1ns/1ps

module rename_stage (
    input  logic           clock,
    input  logic           rst_n,
    input  logic           in_valid,
    input  ooo_pkg::op_e   in_op,
    input  ooo_pkg::arn_t  in_dest,
    input  ooo_pkg::arn_t  in_src1,
    input  ooo_pkg::arn_t  in_src2,
    input  ooo_pkg::word_t in_imm,
    input  logic           rob_full,
    input  logic           iq_full,
    input  ooo_pkg::robn_t rob_tail,
    input  logic           free_valid,
    input  ooo_pkg::prn_t  free_prn,
    output logic           stall,
    dispatch_if.rename     disp
);
    import ooo_pkg::*;

    prn_t map_table [ARCH_REGS];
    prn_t free_list [FREE_REGS];

    logic [$clog2(FREE_REGS)-1:0] fl_head;
    logic [$clog2(FREE_REGS)-1:0] fl_tail;
    logic [$clog2(FREE_REGS):0]   fl_count;
    logic                         fl_empty;
    logic                         accept;

    assign fl_empty = (fl_count == '0);
    assign stall    = fl_empty | rob_full | iq_full;
    assign accept   = in_valid & ~stall;

    // sources see the mapping before this instruction's own write
    assign disp.valid    = accept;
    assign disp.op       = in_op;
    assign disp.imm      = in_imm;
    assign disp.dest_arn = in_dest;
    assign disp.dest_prn = free_list[fl_head];
    assign disp.old_prn  = map_table[in_dest];
    assign disp.src1_prn = map_table[in_src1];
    assign disp.src2_prn = map_table[in_src2];
    assign disp.robn     = rob_tail;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                map_table[i] <= prn_t'(i);
            end
            for (int i = 0; i < FREE_REGS; i++) begin
                free_list[i] <= prn_t'(ARCH_REGS + i);
            end
            fl_head  <= '0;
            fl_tail  <= '0;
            fl_count <= ($clog2(FREE_REGS)+1)'(FREE_REGS);
        end else begin
            if (accept) begin
                map_table[in_dest] <= free_list[fl_head];
                fl_head            <= fl_head + 1'b1;
            end
            // retired old mappings come back here
            if (free_valid) begin
                free_list[fl_tail] <= free_prn;
                fl_tail            <= fl_tail + 1'b1;
            end
            case ({accept, free_valid})
                2'b10:   fl_count <= fl_count - 1'b1;
                2'b01:   fl_count <= fl_count + 1'b1;
                default: fl_count <= fl_count;
            endcase
        end
    end

endmodule

/* rtl/reorder_buffer.sv */
`timescale 1ns/1ps

module reorder_buffer (
    input  logic           clock,
    input  logic           rst_n,
    dispatch_if.rob        disp,
    cdb_if.sink            cdb,
    output logic           rob_full,
    output ooo_pkg::robn_t rob_tail,
    output logic           free_valid,
    output ooo_pkg::prn_t  free_prn,
    output logic           commit_valid,
    output ooo_pkg::arn_t  commit_arn,
    output ooo_pkg::word_t commit_value
);
    import ooo_pkg::*;

    arn_t                 ent_arn [ROB_DEPTH];
    prn_t                 ent_old_prn [ROB_DEPTH];
    word_t                ent_value [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] ent_done;

    robn_t                      head;
    robn_t                      tail;
    logic [$clog2(ROB_DEPTH):0] count;
    logic                       retire;

    assign retire   = (count != '0) && ent_done[head];
    assign rob_full = (count == ($clog2(ROB_DEPTH)+1)'(ROB_DEPTH));
    assign rob_tail = tail;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            ent_done     <= '0;
            commit_valid <= 1'b0;
            free_valid   <= 1'b0;
        end else begin
            if (retire) begin
                ent_done[head] <= 1'b0;
                head           <= head + 1'b1;
            end
            if (disp.valid) begin
                ent_done[disp.robn] <= 1'b0;
                tail                <= tail + 1'b1;
            end
            // completion from the bus
            if (cdb.valid) begin
                ent_done[cdb.robn] <= 1'b1;
            end
            case ({disp.valid, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            commit_valid <= retire;
            free_valid   <= retire;
        end
    end

    always_ff @(posedge clock) begin
        if (disp.valid) begin
            ent_arn[disp.robn]     <= disp.dest_arn;
            ent_old_prn[disp.robn] <= disp.old_prn;
        end
        if (cdb.valid) begin
            ent_value[cdb.robn] <= cdb.value;
        end
        // previous mapping is dead once this instruction retires
        if (retire) begin
            commit_arn   <= ent_arn[head];
            commit_value <= ent_value[head];
            free_prn     <= ent_old_prn[head];
        end
    end

endmodule

/* verification/ooo_assert.sv */
`timescale 1ns/1ps

module ooo_rob_assert (
    input logic                                clock,
    input logic                                rst_n,
    input logic [$clog2(ooo_pkg::ROB_DEPTH):0] count,
    input ooo_pkg::robn_t                      head,
    input logic                                cdb_valid,
    input ooo_pkg::robn_t                      cdb_robn,
    input logic                                commit_valid,
    input logic                                rob_full
);
    import ooo_pkg::*;

    // bus completions per entry, cleared once the entry commits
    logic [ROB_DEPTH-1:0] completed;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            completed <= '0;
        end else begin
            if (commit_valid) begin
                completed[head - 1'b1] <= 1'b0;
            end
            if (cdb_valid) begin
                completed[cdb_robn] <= 1'b1;
            end
        end
    end

    count_bound: assert property (
        @(posedge clock) disable iff (!rst_n)
        count <= ($clog2(ROB_DEPTH)+1)'(ROB_DEPTH)
    ) else $error("reorder buffer count above its depth");

    // head has already advanced when commit_valid is seen
    commit_from_done: assert property (
        @(posedge clock) disable iff (!rst_n)
        commit_valid |-> completed[head - 1'b1]
    ) else $error("commit without a completed head entry");

    quiet_after_reset: assert property (
        @(posedge clock) $rose(rst_n) |-> (!commit_valid && !rob_full)
    ) else $error("commit or full flag high right after reset");

endmodule

/* verification/ooo_tb.sv */
`timescale 1ns/1ps

module ooo_tb;
    import ooo_pkg::*;

    localparam int MAX_VEC        = 64;
    localparam int CYCLES_PER_VEC = 40;

    logic  clock;
    logic  rst_n;
    logic  in_valid;
    op_e   in_op;
    arn_t  in_dest;
    arn_t  in_src1;
    arn_t  in_src2;
    word_t in_imm;
    logic  stall;
    logic  commit_valid;
    arn_t  commit_arn;
    word_t commit_value;

    // op, dest, src1, src2 nibbles, then imm and result
    logic [47:0] vectors [MAX_VEC];
    logic [18:0] expected [$];
    logic [18:0] exp_entry;
    logic [31:0] lfsr;
    int          num_vec = 0;
    int          value_errors;
    int          other_errors;
    int          stall_cycles;

    ooo_core i_dut (
        .clock        (clock),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_op        (in_op),
        .in_dest      (in_dest),
        .in_src1      (in_src1),
        .in_src2      (in_src2),
        .in_imm       (in_imm),
        .stall        (stall),
        .commit_valid (commit_valid),
        .commit_arn   (commit_arn),
        .commit_value (commit_value)
    );

    bind reorder_buffer ooo_rob_assert rob_checks (
        .clock        (clock),
        .rst_n        (rst_n),
        .count        (count),
        .head         (head),
        .cdb_valid    (cdb.valid),
        .cdb_robn     (cdb.robn),
        .commit_valid (commit_valid),
        .rob_full     (rob_full)
    );

    initial clock = 1'b0;
    always #5 clock = ~clock;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // idle roughly one cycle in four
    task automatic roll_idle(output logic idle);
        logic b0;
        logic b1;
        lfsr = lfsr_next(lfsr);
        b0   = lfsr[0];
        lfsr = lfsr_next(lfsr);
        b1   = lfsr[0];
        idle = b0 & b1;
    endtask

    task automatic drive_instr(input logic [47:0] v);
        in_valid = 1'b1;
        in_op    = op_e'(v[46:44]);
        in_dest  = v[42:40];
        in_src1  = v[38:36];
        in_src2  = v[34:32];
        in_imm   = v[31:16];
    endtask

    initial begin
        logic idle;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_op        = OP_ADD;
        in_dest      = '0;
        in_src1      = '0;
        in_src2      = '0;
        in_imm       = '0;
        lfsr         = 32'h4555aaa8;
        value_errors = 0;
        other_errors = 0;
        stall_cycles = 0;
        for (int k = 0; k < MAX_VEC; k++) begin
            vectors[k] = '1;
        end
        $readmemh("verification/ooo_vectors.txt", vectors);
        while (num_vec < MAX_VEC && vectors[num_vec][47:44] != 4'hf) begin
            num_vec++;
        end
        repeat (2) @(negedge clock);
        rst_n = 1'b1;
        @(negedge clock);
        assert (!stall && !commit_valid) else begin
            value_errors++;
            $display("Fail %0t: stall or commit_valid high after reset", $time);
        end
        for (int i = 0; i < num_vec; i++) begin
            roll_idle(idle);
            while (idle) begin
                in_valid = 1'b0;
                @(negedge clock);
                roll_idle(idle);
            end
            drive_instr(vectors[i]);
            // stall seen here holds until the next rising edge
            while (stall) begin
                stall_cycles++;
                @(negedge clock);
            end
            expected.push_back({vectors[i][42:40], vectors[i][15:0]});
            @(negedge clock);
        end
        in_valid = 1'b0;
        while (expected.size() != 0) begin
            @(negedge clock);
        end
        repeat (4) @(negedge clock);
        assert (stall_cycles > 0) else begin
            other_errors++;
            $display("stall never went high during the burst");
        end
        $display("errors: %0d wrong values, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // commits must follow acceptance order
    always @(negedge clock) begin
        if (rst_n && commit_valid) begin
            assert (expected.size() != 0) else begin
                other_errors++;
                $display("commit at %0t with no instruction outstanding", $time);
            end
            if (expected.size() != 0) begin
                exp_entry = expected.pop_front();
                assert (commit_arn == exp_entry[18:16]) else begin
                    value_errors++;
                    $display("Fail %0t: commit register r%0d, expected r%0d",
                             $time, commit_arn, exp_entry[18:16]);
                end
                assert (commit_value == exp_entry[15:0]) else begin
                    value_errors++;
                    $display("Fail %0t: commit value %h, expected %h",
                             $time, commit_value, exp_entry[15:0]);
                end
            end
        end
    end

    // vector count is final once reset is released
    initial begin
        wait (rst_n === 1'b1);
        repeat (num_vec * CYCLES_PER_VEC) @(posedge clock);
        $display("timeout after %0d cycles with %0d commits still missing",
                 num_vec * CYCLES_PER_VEC, expected.size());
        $display("tests failed");
        $finish;
    end

endmodule

/* verification/ooo_vectors.txt */
// one hex word per instruction: op, dest, src1, src2 (one digit each),
// then imm (4 digits) and expected result (4 digits)
410000050005
420012341234
336700000000
041200001239
15120000EDD1
262400001230
37250000FFE5
411000100015
02110000002A
132100000015
33320000003F
243700000025
400000010001
400000010002
400000010003
400000010004
400000010005
400000010006
400000010007
400000010008
400000010009
40000001000A
05040000002F
16510000001A

/* verilog.f */
rtl/ooo_pkg.sv
rtl/dispatch_if.sv
rtl/cdb_if.sv
rtl/rename_stage.sv
rtl/phys_regfile.sv
rtl/issue_exec.sv
rtl/reorder_buffer.sv
rtl/ooo_core.sv
verification/ooo_assert.sv
verification/ooo_tb.sv
